// ==== bench/box_ref.svh ====
/* Reference rules of the box field
   Box position, explosion clearing, pixel hit and player blocking */
`ifndef BOX_REF_SVH
`define BOX_REF_SVH

function automatic int column_x(input int index);
    return ORIGIN_X + (index % GRID_COLS) * BOX_PITCH;
endfunction

function automatic int row_y(input int index);
    return ORIGIN_Y + (index / GRID_COLS) * BOX_PITCH;
endfunction

// Either arm of the plus reaches the box
function automatic bit explosion_clears(input int index, input int ex, input int ey);
    int dx;
    int dy;
    bit along_x;
    bit along_y;
    bit same_row;
    bit same_col;
    dx = column_x(index) - ex;
    dy = row_y(index) - ey;
    along_x = (dx >= -(EXP_REACH_NEG + TILE_W - 1)) && (dx <= EXP_REACH_POS);
    along_y = (dy >= -(EXP_REACH_NEG + TILE_H - 1)) && (dy <= EXP_REACH_POS);
    same_row = (dy > -TILE_H) && (dy < TILE_H);   // Arm is one tile high
    same_col = (dx > -TILE_W) && (dx < TILE_W);
    return (along_x && same_row) || (along_y && same_col);
endfunction

function automatic bit pixel_on_live_box(input int px, input int py, input box_mask_t live);
    int dx;
    int dy;
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_BOXES; i++)
    begin
        dx = px - column_x(i);
        dy = py - row_y(i);
        if (live[i] && dx >= 0 && dx < TILE_W && dy >= 0 && dy < TILE_H)
            hit = 1'b1;
    end
    return hit;
endfunction

// Player offset from each live box decides the blocked sides
function automatic dir_t blocked_dirs(input int px, input int py, input box_mask_t live);
    dir_t dirs;
    int dx;
    int dy;
    bit rows_meet;
    bit cols_meet;
    dirs = '0;
    for (int i = 0; i < NUM_BOXES; i++)
    begin
        dx = px - column_x(i);
        dy = py - row_y(i);
        rows_meet = (dy > -TILE_H) && (dy < TILE_H);
        cols_meet = (dx > -TILE_W) && (dx < TILE_W);
        if (live[i])
        begin
            if (dx >= 0 && dx <= TILE_W && rows_meet)
                dirs[DIR_LEFT] = 1'b1;
            if (dx >= -TILE_W && dx <= 0 && rows_meet)
                dirs[DIR_RIGHT] = 1'b1;
            if (dy >= 0 && dy <= TILE_H && cols_meet)
                dirs[DIR_UP] = 1'b1;
            if (dy >= -TILE_H && dy <= 0 && cols_meet)
                dirs[DIR_DOWN] = 1'b1;
        end
    end
    return dirs;
endfunction

`endif

// ==== bench/box_tb.sv ====
`timescale 1ns/1ps
/* Box field testbench
   Drives pixels, player moves and explosions, checks outputs against a model */
module box_tb import box_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM = 300;
    localparam int SWEEP_CYCLES = NUM_BOXES * 6;
    localparam int STIM_CYCLES = RESET_CYCLES + 3 * SWEEP_CYCLES + 2 * NUM_RANDOM + 64;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic   clk = 1'b0;
    logic   reset;
    coord_t v_x;
    coord_t v_y;
    coord_t b_x;
    coord_t b_y;
    coord_t e_x;
    coord_t e_y;
    logic   explosion_pulse;
    logic   box_on;
    dir_t   player_blocked;

    box_mask_t model_alive;
    logic      exp_box_on;
    dir_t      exp_blocked;
    integer    seed;
    int        check_count = 0;
    int        error_count = 0;
    int        cycle_count = 0;

    `include "box_ref.svh"

    box_top uut (
        .clk             (clk),
        .reset           (reset),
        .v_x             (v_x),
        .v_y             (v_y),
        .b_x             (b_x),
        .b_y             (b_y),
        .e_x             (e_x),
        .e_y             (e_y),
        .explosion_pulse (explosion_pulse),
        .box_on          (box_on),
        .player_blocked  (player_blocked)
    );

    always #10 clk = ~clk;

    // Model sees the inputs the DUT samples on the same edge
    always @(posedge clk or posedge reset)
    begin
        box_mask_t next_alive;
        if (reset)
        begin
            model_alive <= '1;
            exp_box_on <= 1'b0;
            exp_blocked <= '0;
        end
        else
        begin
            next_alive = model_alive;
            if (explosion_pulse)
                for (int i = 0; i < NUM_BOXES; i++)
                    if (explosion_clears(i, e_x, e_y))
                        next_alive[i] = 1'b0;
            exp_box_on <= pixel_on_live_box(v_x, v_y, next_alive);   // Mask of this cycle
            exp_blocked <= blocked_dirs(b_x, b_y, model_alive);
            model_alive <= next_alive;
        end
    end

    assert property (@(posedge clk) reset |-> (box_on == 1'b0 && player_blocked == '0))
        check_count++;
    else
    begin
        error_count++;
        $display("Fail at %0t: outputs not cleared during reset", $time);
    end

    assert property (@(posedge clk) disable iff (reset) box_on == exp_box_on)
        check_count++;
    else
    begin
        error_count++;
        $display("Fail at %0t: box_on is %b, expected %b", $time,
                 $sampled(box_on), $sampled(exp_box_on));
    end

    assert property (@(posedge clk) disable iff (reset) player_blocked == exp_blocked)
        check_count++;
    else
    begin
        error_count++;
        $display("Fail at %0t: player_blocked is %b, expected %b", $time,
                 $sampled(player_blocked), $sampled(exp_blocked));
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: stimulus still running after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic apply_pixel(input int x, input int y);
        @(posedge clk);
        v_x <= coord_t'(x);
        v_y <= coord_t'(y);
    endtask

    task automatic place_player(input int x, input int y);
        @(posedge clk);
        b_x <= coord_t'(x);
        b_y <= coord_t'(y);
    endtask

    task automatic fire_explosion(input int x, input int y);
        @(posedge clk);
        e_x <= coord_t'(x);
        e_y <= coord_t'(y);
        explosion_pulse <= 1'b1;
        @(posedge clk);
        explosion_pulse <= 1'b0;
    endtask

    // Corner pixels of every box and one pixel just outside
    task automatic sweep_box_edges();
        int bx;
        int by;
        for (int i = 0; i < NUM_BOXES; i++)
        begin
            bx = column_x(i);
            by = row_y(i);
            apply_pixel(bx, by);
            apply_pixel(bx + TILE_W - 1, by);
            apply_pixel(bx, by + TILE_H - 1);
            apply_pixel(bx + TILE_W - 1, by + TILE_H - 1);
            apply_pixel(bx - 1, by);
            apply_pixel(bx + TILE_W, by + TILE_H - 1);
        end
    endtask

    task automatic scatter_pixels();
        int span_x;
        int span_y;
        span_x = (GRID_COLS - 1) * BOX_PITCH + TILE_W + 8;
        span_y = (GRID_ROWS - 1) * BOX_PITCH + TILE_H + 8;
        for (int n = 0; n < NUM_RANDOM; n++)
            apply_pixel(ORIGIN_X - 4 + $unsigned($random(seed)) % span_x,
                        ORIGIN_Y - 4 + $unsigned($random(seed)) % span_y);
    endtask

    // Player touching each side of a box, then open space
    task automatic probe_around_box(input int index);
        int bx;
        int by;
        bx = column_x(index);
        by = row_y(index);
        place_player(bx + TILE_W, by);
        place_player(bx - TILE_W, by + 3);
        place_player(bx, by + TILE_H);
        place_player(bx - 5, by - TILE_H);
        place_player(bx + TILE_W + 1, by + TILE_H + 1);
        place_player(20, 400);
    endtask

    initial
    begin
        seed = 32'he2f4c849;
        reset <= 1'b1;   // Rising edge lands after every process waits on it
        v_x = '0;
        v_y = '0;
        b_x = '0;
        b_y = '0;
        e_x = '0;
        e_y = '0;
        explosion_pulse = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        sweep_box_edges();
        scatter_pixels();
        probe_around_box(5);
        probe_around_box(6);

        fire_explosion(column_x(5), row_y(5));
        sweep_box_edges();
        probe_around_box(5);
        probe_around_box(6);

        fire_explosion(column_x(15) + 4, row_y(15));
        fire_explosion(column_x(1), row_y(1) + 2);   // Overlaps cleared boxes only in part
        fire_explosion(600, 400);                    // Far from the board
        sweep_box_edges();
        scatter_pixels();
        probe_around_box(15);
        probe_around_box(0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== logic/box_pkg.sv ====
/* Box field geometry for the game board
   Grid layout, tile size, explosion reach and blocked-direction bits */
package box_pkg;

    localparam int COORD_W = 10;   // Screen coordinate width

    // Board is a square grid, index = row * GRID_COLS + column
    localparam int GRID_COLS = 4;
    localparam int GRID_ROWS = 4;
    localparam int NUM_BOXES = GRID_COLS * GRID_ROWS;

    localparam int ORIGIN_X = 143;   // Top-left corner of box 0
    localparam int ORIGIN_Y = 34;
    localparam int BOX_PITCH = 32;   // Same step in x and y

    // Box tile size, the player sprite is the same size
    localparam int TILE_W = 16;
    localparam int TILE_H = 16;

    // Explosion arm reach from the explosion point
    localparam int EXP_REACH_NEG = 48;   // Left and up
    localparam int EXP_REACH_POS = 63;   // Right and down

    // Bits of the blocked vector
    localparam int NUM_DIRS = 4;
    localparam int DIR_LEFT = 0;
    localparam int DIR_RIGHT = 1;
    localparam int DIR_UP = 2;
    localparam int DIR_DOWN = 3;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [NUM_DIRS-1:0] dir_t;
    typedef logic [NUM_BOXES-1:0] box_mask_t;

    // Left edge of a box
    function automatic coord_t box_x_of(input int index);
        int col;
        col = index % GRID_COLS;
        return coord_t'(ORIGIN_X + col * BOX_PITCH);
    endfunction

    // Top edge of a box
    function automatic coord_t box_y_of(input int index);
        int row;
        row = index / GRID_COLS;
        return coord_t'(ORIGIN_Y + row * BOX_PITCH);
    endfunction

endpackage

// ==== logic/box_store.sv ====
`timescale 1ns/1ps
/* Box store
   Alive bit per box, cleared when a plus-shaped explosion covers the box */
module box_store import box_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coord_t    e_x,
    input  coord_t    e_y,
    input  logic      explosion_pulse,
    output box_mask_t alive
);

    localparam box_mask_t ALIVE_RESET = '1;   // Full board

    box_mask_t hit;   // Boxes under either arm of the explosion

    // Two inclusive ranges share at least one point
    function automatic logic overlaps(
        input int a_lo,
        input int a_hi,
        input int b_lo,
        input int b_hi
    );
        return (a_lo <= b_hi) && (a_hi >= b_lo);
    endfunction

    // Signed math so arms reaching past the screen edge do not wrap
    always_comb
    begin
        int ex;
        int ey;
        int bx;
        int by;
        logic arm_h;
        logic arm_v;

        ex = int'(e_x);
        ey = int'(e_y);
        for (int i = 0; i < NUM_BOXES; i++)
        begin
            bx = int'(box_x_of(i));
            by = int'(box_y_of(i));

            // Horizontal arm, one tile high
            arm_h = overlaps(bx, bx + TILE_W - 1, ex - EXP_REACH_NEG, ex + EXP_REACH_POS)
                 && overlaps(by, by + TILE_H - 1, ey, ey + TILE_H - 1);

            // Vertical arm, one tile wide
            arm_v = overlaps(by, by + TILE_H - 1, ey - EXP_REACH_NEG, ey + EXP_REACH_POS)
                 && overlaps(bx, bx + TILE_W - 1, ex, ex + TILE_W - 1);

            hit[i] = arm_h || arm_v;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            alive <= ALIVE_RESET;
        else if (explosion_pulse)
            alive <= alive & ~hit;   // Cleared boxes stay cleared
    end

endmodule

// ==== logic/box_top.sv ====
`timescale 1ns/1ps
/* Box field top level
   Box store feeding the pixel hit flag and the player move blocker */
module box_top import box_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  coord_t v_x,               // Current VGA pixel
    input  coord_t v_y,
    input  coord_t b_x,               // Player position
    input  coord_t b_y,
    input  coord_t e_x,               // Explosion point
    input  coord_t e_y,
    input  logic   explosion_pulse,   // One-cycle strobe
    output logic   box_on,
    output dir_t   player_blocked
);

    box_mask_t alive;

    box_store u_store (
        .clk             (clk),
        .reset           (reset),
        .e_x             (e_x),
        .e_y             (e_y),
        .explosion_pulse (explosion_pulse),
        .alive           (alive)
    );

    pixel_hit u_pixel (
        .clk    (clk),
        .reset  (reset),
        .v_x    (v_x),
        .v_y    (v_y),
        .alive  (alive),
        .box_on (box_on)
    );

    move_blocker u_blocker (
        .clk            (clk),
        .reset          (reset),
        .b_x            (b_x),
        .b_y            (b_y),
        .alive          (alive),
        .player_blocked (player_blocked)
    );

endmodule

// ==== logic/move_blocker.sv ====
`timescale 1ns/1ps
/* Move blocker
   Registered blocked-direction flags of the player against all live boxes */
module move_blocker import box_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coord_t    b_x,
    input  coord_t    b_y,
    input  box_mask_t alive,
    output dir_t      player_blocked
);

    dir_t blocked_next;

    always_comb
    begin
        int px;
        int py;
        int bx;
        int by;
        logic x_overlap;
        logic y_overlap;

        px = int'(b_x);
        py = int'(b_y);
        blocked_next = '0;
        for (int i = 0; i < NUM_BOXES; i++)
        begin
            bx = int'(box_x_of(i));
            by = int'(box_y_of(i));

            // Player sprite and box share rows or columns
            y_overlap = (py <= by + TILE_H - 1) && (py + TILE_H - 1 >= by);
            x_overlap = (px <= bx + TILE_W - 1) && (px + TILE_W - 1 >= bx);

            if (alive[i])   // Cleared boxes never block
            begin
                // Player right of the box, touching or inside
                if ((px >= bx) && (px <= bx + TILE_W) && y_overlap)
                    blocked_next[DIR_LEFT] = 1'b1;

                // Player left of the box
                if ((px >= bx - TILE_W) && (px <= bx) && y_overlap)
                    blocked_next[DIR_RIGHT] = 1'b1;

                // Player below the box
                if ((py >= by) && (py <= by + TILE_H) && x_overlap)
                    blocked_next[DIR_UP] = 1'b1;

                // Player above the box
                if ((py >= by - TILE_H) && (py <= by) && x_overlap)
                    blocked_next[DIR_DOWN] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            player_blocked <= '0;
        else
            player_blocked <= blocked_next;
    end

endmodule

// ==== logic/pixel_hit.sv ====
`timescale 1ns/1ps
/* Pixel hit
   Flags a VGA pixel that falls inside any live box */
module pixel_hit import box_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coord_t    v_x,
    input  coord_t    v_y,
    input  box_mask_t alive,
    output logic      box_on
);

    box_mask_t in_area_next;
    box_mask_t in_area;   // Pixel of the previous cycle, per box

    always_comb
    begin
        int px;
        int py;
        int bx;
        int by;

        px = int'(v_x);
        py = int'(v_y);
        for (int i = 0; i < NUM_BOXES; i++)
        begin
            bx = int'(box_x_of(i));
            by = int'(box_y_of(i));
            in_area_next[i] = (px >= bx) && (px <= bx + TILE_W - 1)
                           && (py >= by) && (py <= by + TILE_H - 1);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            in_area <= '0;
        else
            in_area <= in_area_next;
    end

    // Alive mask taken as it stands now, not delayed
    assign box_on = |(in_area & alive);

endmodule

// ==== sim.f ====
+incdir+bench
logic/box_pkg.sv
logic/box_store.sv
logic/pixel_hit.sv
logic/move_blocker.sv
logic/box_top.sv
bench/box_tb.sv
